//--- support_logic.f
+incdir+.
support_logic_pkg.sv
obi_phase_monitor.sv
req_attribute_fifo.sv
debug_entry_fsm.sv
exception_trigger_unit.sv
irq_event_counter.sv
support_logic.sv
support_logic_assert.sv
tb_support_logic.sv

//--- support_logic_input.txt
# fe dq ak st ii di v dm dr tr ex cs in ics mm um ps mx ib db tw ts td1 td2 (inputs)
# ff fd rd ra th ca cr io do ws dI iI gi gd (expected, bus nibble is req gnt gntpar rvalid)
0 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 1 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 1 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 1 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 1 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 1 1 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 1 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 1 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 1 0 50000200 00000008 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 1 4 50000240 00000004 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 1 1 03 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 1 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 1 1 03 0 000 0 1 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 1 1 02 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 1 6 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 1 0 1 0 0 0 0 0 00 0 000 1 0 0 0 0 c 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 c 0 0 00000000 00000000 0 0 0 0 0 00 00 0 1 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 1 0 00 00 0 2 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 1 0 00 00 0 2 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 1 0 0 00000000 00000000 0 0 0 0 0 00 00 0 2 1 1 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 1 0 0 00000000 00000000 0 0 0 0 0 00 00 0 1 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 1 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 1 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 1 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 1 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 1 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 1 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 1 0 0 0 0 0 0 00 0 000 1 0 0 0 8 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 1 0 0 0 0 0 0 00 0 000 1 0 0 0 c 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 c 0 0 0 00000000 00000000 0 0 0 0 0 00 00 1 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 1 0 0 0 00000000 00000000 0 0 0 0 0 00 00 2 0 0 0 1 1 0
1 0 0 0 1 0 0 0 0 0 0 00 0 000 1 0 0 0 d 0 0 0 00000000 00000000 0 0 0 0 0 00 00 1 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 1 0 0 0 00000000 00000000 0 0 0 0 0 00 00 1 0 0 0 1 0 0
1 0 0 1 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 e 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 1 0 0 00000000 00000000 0 0 0 0 0 00 00 0 1 1 0 0 0 1
1 0 1 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 00 00 0 0 0 0 0 0 0
1 0 1 0 0 0 1 0 0 0 0 00 1 003 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 01 00 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 1 400 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 02 01 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 1 403 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 02 01 0 0 0 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 00 1 404 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 02 01 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 1 007 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 02 02 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 00 0 000 1 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 02 02 0 0 0 0 0 0 0

//--- tb_support_logic.sv
// drives support_logic from support_logic_input.txt, one data line per cycle
// attribute outputs are only compared in cycles with a response on that bus
`timescale 1ns/100ps

module tb_support_logic;

  localparam int NFIELDS = 38;

  logic                              clk = 1'b0;
  logic                              rst_n;
  support_logic_pkg::retire_t        retire;
  support_logic_pkg::ctrl_t          ctrl;
  support_logic_pkg::obi_bus_t       instr_bus;
  support_logic_pkg::obi_bus_t       data_bus;
  support_logic_pkg::trig_wr_t       trig_wr;
  logic                              fetch_enable;
  logic                              debug_req;
  logic                              irq_ack;
  logic                              req_is_store;
  logic                              req_instr_integrity;
  logic                              req_data_integrity;
  support_logic_pkg::support_flags_t flags;

  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;
  logic [31:0] f [0:NFIELDS+1];
  // bus nibbles of the previous line, reset leaves both idle
  logic [3:0]  instr_bus_prev = 4'h0;
  logic [3:0]  data_bus_prev = 4'h0;

  always #2 clk = ~clk;

  support_logic support_logic_i (
    .in_support_if         (clk),
    .rst_n_i               (rst_n),
    .retire_i              (retire),
    .ctrl_i                (ctrl),
    .instr_bus_i           (instr_bus),
    .data_bus_i            (data_bus),
    .trig_wr_i             (trig_wr),
    .fetch_enable_i        (fetch_enable),
    .debug_req_i           (debug_req),
    .irq_ack_i             (irq_ack),
    .req_is_store_i        (req_is_store),
    .req_instr_integrity_i (req_instr_integrity),
    .req_data_integrity_i  (req_data_integrity),
    .flags_o               (flags)
  );

  bind support_logic support_logic_assert u_sl_assert (.*);

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic bit is_data_line(input string s);
    return s.len() > 1 && s[0] != "#";
  endfunction

  // splits a line on white space, returns the number of hex fields
  function automatic int split_hex(input string s);
    int k;
    int start;
    byte c;
    bit sep;
    k = 0;
    start = -1;
    for (int i = 0; i <= s.len(); i++) begin
      c = (i < s.len()) ? s[i] : " ";
      sep = (c == " " || c == "\t" || c == "\n" || c == "\r");
      if (!sep && start < 0) begin
        start = i;
      end else if (sep && start >= 0) begin
        if (k <= NFIELDS + 1) begin
          void'($sscanf(s.substr(start, i - 1), "%h", f[k]));
        end
        k++;
        start = -1;
      end
    end
    return k;
  endfunction

  task automatic drive_line();
    fetch_enable        <= f[0][0];
    debug_req           <= f[1][0];
    irq_ack             <= f[2][0];
    req_is_store        <= f[3][0];
    req_instr_integrity <= f[4][0];
    req_data_integrity  <= f[5][0];
    retire.valid           <= f[6][0];
    retire.dbg_mode        <= f[7][0];
    retire.is_dret         <= f[8][0];
    retire.trap            <= f[9][0];
    retire.exception       <= f[10][0];
    retire.exception_cause <= f[11][5:0];
    retire.intr            <= f[12][0];
    retire.intr_cause      <= f[13][10:0];
    retire.is_mmode        <= f[14][0];
    retire.is_umode        <= f[15][0];
    ctrl.pc_set  <= f[16][0];
    ctrl.pc_mux  <= support_logic_pkg::pc_mux_e'(f[17][2:0]);
    instr_bus    <= support_logic_pkg::obi_bus_t'(f[18][3:0]);
    data_bus     <= support_logic_pkg::obi_bus_t'(f[19][3:0]);
    trig_wr.valid   <= f[20][0];
    trig_wr.tselect <= f[21][2:0];
    trig_wr.tdata1  <= f[22];
    trig_wr.tdata2  <= f[23];
  endtask

  task automatic check_line();
    check_value("first_fetch", 32'(flags.first_fetch), f[24]);
    check_value("first_debug_ins", 32'(flags.first_debug_ins), f[25]);
    check_value("recorded_dbg_req", 32'(flags.recorded_dbg_req), f[26]);
    check_value("req_after_exception", 32'(flags.req_after_exception), f[27]);
    check_value("exc_trigger_hit", 32'(flags.exc_trigger_hit), f[28]);
    check_value("cnt_irq_ack", 32'(flags.cnt_irq_ack), f[29]);
    check_value("cnt_rvfi_irqs", 32'(flags.cnt_rvfi_irqs), f[30]);
    check_value("instr_outstanding", 32'(flags.instr_bus.outstanding), f[31]);
    check_value("data_outstanding", 32'(flags.data_bus.outstanding), f[32]);
    // a request without a grant in the previous cycle continues its address phase
    check_value("instr_addr_ph_cont", 32'(flags.instr_bus.addr_ph_cont),
                32'(instr_bus_prev[3] && !instr_bus_prev[2]));
    check_value("data_addr_ph_cont", 32'(flags.data_bus.addr_ph_cont),
                32'(data_bus_prev[3] && !data_bus_prev[2]));
    // response phase lasts while anything is outstanding
    check_value("instr_resp_ph_cont", 32'(flags.instr_bus.resp_ph_cont), 32'(f[31] != 0));
    check_value("data_resp_ph_cont", 32'(flags.data_bus.resp_ph_cont), 32'(f[32] != 0));
    // attributes are only defined while a response is present
    if (f[19][0]) begin
      check_value("req_was_store", 32'(flags.req_was_store), f[33]);
      check_value("data_req_had_integrity", 32'(flags.data_req_had_integrity), f[34]);
      check_value("gntpar_err_in_resp_data", 32'(flags.gntpar_err_in_resp_data), f[37]);
    end
    if (f[18][0]) begin
      check_value("instr_req_had_integrity", 32'(flags.instr_req_had_integrity), f[35]);
      check_value("gntpar_err_in_resp_instr", 32'(flags.gntpar_err_in_resp_instr), f[36]);
    end
    instr_bus_prev = f[18][3:0];
    data_bus_prev  = f[19][3:0];
  endtask

  // ----------------------------------------
  // timeout
  // ----------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the stimulus did not finish", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int    fd;
    int    nlines;
    int    n;
    string line;
    rst_n               = 1'b0;
    retire              = '0;
    ctrl                = '0;
    instr_bus           = '0;
    data_bus            = '0;
    trig_wr             = '0;
    fetch_enable        = 1'b0;
    debug_req           = 1'b0;
    irq_ack             = 1'b0;
    req_is_store        = 1'b0;
    req_instr_integrity = 1'b0;
    req_data_integrity  = 1'b0;
    nlines = 0;

    fd = $fopen("support_logic_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open support_logic_input.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (is_data_line(line)) begin
          nlines++;
        end
      end
      $fclose(fd);
      limit = 2 * nlines + 20;
      fd = $fopen("support_logic_input.txt", "r");

      // reset is released at the fourth edge, together with the first line
      repeat (3) @(posedge clk);
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (is_data_line(line)) begin
          n = split_hex(line);
          if (n != NFIELDS) begin
            errors++;
            $display("input line has %0d fields instead of %0d", n, NFIELDS);
          end else begin
            @(posedge clk);
            rst_n <= 1'b1;
            drive_line();
            @(negedge clk);
            check_line();
          end
        end
      end
      $fclose(fd);
      @(posedge clk);
    end

    $display("errors: %0d compare, %0d assertion", errors,
             support_logic_i.u_sl_assert.fail_cnt);
    errors += support_logic_i.u_sl_assert.fail_cnt;
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- support_logic_assert.sv
// bound into support_logic, checks OBI stimulus against the FIFO depth
// debug entry is tracked from the retirement stream alone
`timescale 1ns/100ps
`include "support_logic_config.svh"

module support_logic_assert (
  input logic                              in_support_if,
  input logic                              rst_n_i,
  input support_logic_pkg::retire_t        retire_i,
  input support_logic_pkg::obi_bus_t       instr_bus_i,
  input support_logic_pkg::obi_bus_t       data_bus_i,
  input support_logic_pkg::support_flags_t flags_o
);

  int   fail_cnt = 0;
  logic in_debug_q;

  // last retirement was in debug mode and did not leave it through a dret
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      in_debug_q <= 1'b0;
    end else if (retire_i.valid) begin
      in_debug_q <= retire_i.dbg_mode && !(retire_i.is_dret && !retire_i.trap);
    end
  end

  // ----------------------------------------
  // FIFO range
  // ----------------------------------------
  a_instr_no_pop_empty: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    instr_bus_i.rvalid |-> flags_o.instr_bus.outstanding != 0)
    else begin
      fail_cnt++;
      $error("instr response with nothing outstanding");
    end

  a_data_no_pop_empty: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    data_bus_i.rvalid |-> flags_o.data_bus.outstanding != 0)
    else begin
      fail_cnt++;
      $error("data response with nothing outstanding");
    end

  a_data_no_push_full: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    (data_bus_i.req && data_bus_i.gnt && !data_bus_i.rvalid)
      |-> flags_o.data_bus.outstanding < `SL_FIFO_DEPTH)
    else begin
      fail_cnt++;
      $error("data grant while the attribute FIFO is full");
    end

  a_outst_in_range: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    flags_o.instr_bus.outstanding <= `SL_FIFO_DEPTH &&
    flags_o.data_bus.outstanding <= `SL_FIFO_DEPTH)
    else begin
      fail_cnt++;
      $error("outstanding count above the FIFO depth");
    end

  // first debug instruction must be a debug-mode retirement entering debug mode
  a_first_dbg_in_dbg: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    flags_o.first_debug_ins |-> retire_i.dbg_mode && !in_debug_q)
    else begin
      fail_cnt++;
      $error("first debug instruction outside debug entry");
    end

endmodule

//--- support_logic.sv
// support monitor top, watches retirement, trap control and both OBI buses
// it never stalls the buses, so stimulus must keep the FIFOs in range
`timescale 1ns/100ps
`include "support_logic_config.svh"

module support_logic (
  input  logic                              in_support_if,
  input  logic                              rst_n_i,
  input  support_logic_pkg::retire_t        retire_i,
  input  support_logic_pkg::ctrl_t          ctrl_i,
  input  support_logic_pkg::obi_bus_t       instr_bus_i,
  input  support_logic_pkg::obi_bus_t       data_bus_i,
  input  support_logic_pkg::trig_wr_t       trig_wr_i,
  input  logic                              fetch_enable_i,
  input  logic                              debug_req_i,
  input  logic                              irq_ack_i,
  input  logic                              req_is_store_i,
  input  logic                              req_instr_integrity_i,
  input  logic                              req_data_integrity_i,
  output support_logic_pkg::support_flags_t flags_o
);

  support_logic_pkg::bus_flags_t instr_flags;
  support_logic_pkg::bus_flags_t data_flags;
  logic                 fetch_seen_q;
  logic                 irq_retired;
  logic                 instr_gntpar_err;
  logic                 data_gntpar_err;
  logic                 first_debug_ins;
  logic                 recorded_dbg_req;
  logic                 req_after_exception;
  logic                 exc_trigger_hit;
  logic [`SL_CNT_W-1:0] cnt_irq_ack;
  logic [`SL_CNT_W-1:0] cnt_rvfi_irqs;
  logic                 req_was_store;
  logic                 data_integrity;
  logic                 instr_integrity;
  logic                 instr_gntpar_resp;
  logic                 data_gntpar_resp;

  // core start, remembered until reset
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // bus phase monitors
  // ----------------------------------------
  obi_phase_monitor u_instr_mon (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .flags_o       (instr_flags),
    .gntpar_err_o  (instr_gntpar_err)
  );

  obi_phase_monitor u_data_mon (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .flags_o       (data_flags),
    .gntpar_err_o  (data_gntpar_err)
  );

  // ----------------------------------------
  // request attributes returned with responses
  // ----------------------------------------
  req_attribute_fifo u_data_store_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .attr_i        (req_is_store_i),
    .attr_o        (req_was_store)
  );

  req_attribute_fifo u_data_integrity_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .attr_i        (req_data_integrity_i),
    .attr_o        (data_integrity)
  );

  req_attribute_fifo u_instr_integrity_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .attr_i        (req_instr_integrity_i),
    .attr_o        (instr_integrity)
  );

  req_attribute_fifo u_instr_gntpar_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_gntpar_err),
    .attr_o        (instr_gntpar_resp)
  );

  req_attribute_fifo u_data_gntpar_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .attr_i        (data_gntpar_err),
    .attr_o        (data_gntpar_resp)
  );

  // ----------------------------------------
  // debug, traps and triggers
  // ----------------------------------------
  debug_entry_fsm u_debug_fsm (
    .in_support_if         (in_support_if),
    .rst_n_i               (rst_n_i),
    .retire_i              (retire_i),
    .ctrl_i                (ctrl_i),
    .data_bus_i            (data_bus_i),
    .debug_req_i           (debug_req_i),
    .first_debug_ins_o     (first_debug_ins),
    .recorded_dbg_req_o    (recorded_dbg_req),
    .req_after_exception_o (req_after_exception)
  );

  exception_trigger_unit u_etrig (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .trig_wr_i     (trig_wr_i),
    .retire_i      (retire_i),
    .hit_o         (exc_trigger_hit)
  );

  // causes 1024 to 1027 are NMIs and are not counted
  assign irq_retired = retire_i.valid && retire_i.intr &&
                       !(retire_i.intr_cause inside {[11'd1024:11'd1027]});

  irq_event_counter u_irq_ack_cnt (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .inc_i         (irq_ack_i),
    .count_o       (cnt_irq_ack)
  );

  irq_event_counter u_irq_ret_cnt (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .inc_i         (irq_retired),
    .count_o       (cnt_rvfi_irqs)
  );

  assign flags_o = '{
    first_fetch:              fetch_enable_i && !fetch_seen_q,
    first_debug_ins:          first_debug_ins,
    recorded_dbg_req:         recorded_dbg_req,
    req_after_exception:      req_after_exception,
    exc_trigger_hit:          exc_trigger_hit,
    cnt_irq_ack:              cnt_irq_ack,
    cnt_rvfi_irqs:            cnt_rvfi_irqs,
    instr_bus:                instr_flags,
    data_bus:                 data_flags,
    req_was_store:            req_was_store,
    data_req_had_integrity:   data_integrity,
    instr_req_had_integrity:  instr_integrity,
    gntpar_err_in_resp_instr: instr_gntpar_resp,
    gntpar_err_in_resp_data:  data_gntpar_resp
  };

endmodule

//--- irq_event_counter.sv
// counts single-cycle events, holds at all ones
`timescale 1ns/100ps
`include "support_logic_config.svh"

module irq_event_counter (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  logic                 inc_i,
  output logic [`SL_CNT_W-1:0] count_o
);

  logic [`SL_CNT_W-1:0] cnt_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (inc_i && cnt_q != '1) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign count_o = cnt_q;

endmodule

//--- exception_trigger_unit.sv
// shadows trigger CSR writes, so it is only valid if every write is reported
// exception causes of 32 and above never hit
`timescale 1ns/100ps
`include "support_logic_config.svh"

module exception_trigger_unit (
  input  logic                        in_support_if,
  input  logic                        rst_n_i,
  input  support_logic_pkg::trig_wr_t trig_wr_i,
  input  support_logic_pkg::retire_t  retire_i,
  output logic                        hit_o
);

  // type 15, trigger disabled
  localparam logic [31:0] TDATA1_DEFAULT = 32'hF800_0000;

  support_logic_pkg::tdata1_u [`SL_MAX_TRIGGERS-1:0] tdata1_q;
  logic [`SL_MAX_TRIGGERS-1:0][31:0]                 tdata2_q;
  logic [`SL_MAX_TRIGGERS-1:0]                       slot_hit;
  logic                                              exc_valid;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      tdata1_q <= {`SL_MAX_TRIGGERS{TDATA1_DEFAULT}};
      tdata2_q <= '0;
    end else if (trig_wr_i.valid && trig_wr_i.tselect < `SL_MAX_TRIGGERS) begin
      tdata1_q[trig_wr_i.tselect] <= trig_wr_i.tdata1;
      tdata2_q[trig_wr_i.tselect] <= trig_wr_i.tdata2;
    end
  end

  assign exc_valid = retire_i.valid && retire_i.exception && !retire_i.exception_cause[5];

  // ----------------------------------------
  // per slot match
  // ----------------------------------------
  for (genvar t = 0; t < `SL_MAX_TRIGGERS; t++) begin : g_slot
    if (t < `SL_NUM_TRIGGERS) begin : g_impl
      assign slot_hit[t] = exc_valid
        && tdata1_q[t].generic.ttype == 4'd5
        && tdata2_q[t][retire_i.exception_cause[4:0]]
        && ((retire_i.is_mmode && tdata1_q[t].etrig.m) ||
            (retire_i.is_umode && tdata1_q[t].etrig.u));
    end else begin : g_unimpl
      // slot not implemented by the core
      assign slot_hit[t] = 1'b0;
    end
  end

  assign hit_o = |slot_hit;

endmodule

//--- debug_entry_fsm.sv
// debug entry, dret re-arm, debug request window and post-trap data requests
// a trap and a retirement in one cycle count as the trap
`timescale 1ns/100ps

module debug_entry_fsm (
  input  logic                        in_support_if,
  input  logic                        rst_n_i,
  input  support_logic_pkg::retire_t  retire_i,
  input  support_logic_pkg::ctrl_t    ctrl_i,
  input  support_logic_pkg::obi_bus_t data_bus_i,
  input  logic                        debug_req_i,
  output logic                        first_debug_ins_o,
  output logic                        recorded_dbg_req_o,
  output logic                        req_after_exception_o
);

  typedef enum logic [1:0] {
    NORMAL,
    IN_DEBUG,
    DRET_SEEN,
    TRAP_WINDOW
  } state_e;

  state_e     state_q;
  state_e     state_d;
  state_e     retire_next;
  logic       trap_taken;
  logic       data_gnt_q;
  logic       req_after_exc_q;
  logic       dbg_req_q;
  logic [1:0] ret_cnt_q;

  assign trap_taken = ctrl_i.pc_set &&
                      (ctrl_i.pc_mux == support_logic_pkg::PC_TRAP_EXC ||
                       ctrl_i.pc_mux == support_logic_pkg::PC_TRAP_DBE);

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_comb begin
    if (retire_i.is_dret && !retire_i.trap) begin
      retire_next = DRET_SEEN;
    end else if (retire_i.dbg_mode) begin
      retire_next = IN_DEBUG;
    end else begin
      retire_next = NORMAL;
    end

    if (trap_taken) begin
      state_d = TRAP_WINDOW;
    end else if (retire_i.valid) begin
      state_d = retire_next;
    end else if (state_q == DRET_SEEN) begin
      // dret seen lasts one cycle
      state_d = NORMAL;
    end else begin
      state_d = state_q;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      state_q <= NORMAL;
    end else begin
      state_q <= state_d;
    end
  end

  assign first_debug_ins_o = retire_i.valid && retire_i.dbg_mode &&
                             (state_q == NORMAL || state_q == DRET_SEEN);

  // ----------------------------------------
  // data request after a trap
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      data_gnt_q      <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.req && data_bus_i.gnt;
      if (trap_taken) begin
        if (data_bus_i.req && data_gnt_q) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        req_after_exc_q <= 1'b0;
      end else if (state_q == TRAP_WINDOW && data_bus_i.req && data_gnt_q) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  assign req_after_exception_o = req_after_exc_q;

  // ----------------------------------------
  // debug request held over retirements
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      dbg_req_q <= 1'b0;
      ret_cnt_q <= 2'd0;
    end else if (retire_i.valid) begin
      if (debug_req_i) begin
        dbg_req_q <= 1'b1;
        ret_cnt_q <= 2'd1;
      end else if (ret_cnt_q != 2'd0) begin
        ret_cnt_q <= ret_cnt_q - 2'd1;
      end else begin
        dbg_req_q <= 1'b0;
      end
    end else if (debug_req_i) begin
      dbg_req_q <= 1'b1;
      ret_cnt_q <= 2'd2;
    end
  end

  assign recorded_dbg_req_o = dbg_req_q;

endmodule

//--- req_attribute_fifo.sv
// one attribute bit per granted request, returned in order on rvalid
// pushing when full or popping when empty corrupts the order
`timescale 1ns/100ps
`include "support_logic_config.svh"

module req_attribute_fifo (
  input  logic                        in_support_if,
  input  logic                        rst_n_i,
  input  support_logic_pkg::obi_bus_t bus_i,
  input  logic                        attr_i,
  output logic                        attr_o
);

  localparam int DEPTH = `SL_FIFO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  logic [DEPTH-1:0] mem;
  // extra top bit tells full from empty
  logic [AW:0]      wr_ptr_q;
  logic [AW:0]      rd_ptr_q;
  logic             push;
  logic             pop;

  assign push = bus_i.req && bus_i.gnt;
  assign pop  = bus_i.rvalid;

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr_q[AW-1:0]] <= attr_i;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // head entry belongs to the response in this cycle
  assign attr_o = mem[rd_ptr_q[AW-1:0]];

endmodule

//--- obi_phase_monitor.sv
// in-order OBI only, one response per granted request
// the outstanding counter is not guarded against overflow
`timescale 1ns/100ps
`include "support_logic_config.svh"

module obi_phase_monitor (
  input  logic                          in_support_if,
  input  logic                          rst_n_i,
  input  support_logic_pkg::obi_bus_t   bus_i,
  output support_logic_pkg::bus_flags_t flags_o,
  output logic                          gntpar_err_o
);

  logic                   addr_done;
  logic                   stall_q;
  logic                   gntpar_err_q;
  logic [`SL_OUTST_W-1:0] outst_q;

  assign addr_done = bus_i.req && bus_i.gnt;

  // ----------------------------------------
  // address and response phases
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      stall_q <= 1'b0;
      outst_q <= '0;
    end else begin
      stall_q <= bus_i.req && !bus_i.gnt;
      // a grant and a response in one cycle leave the count unchanged
      if (addr_done && !bus_i.rvalid) begin
        outst_q <= outst_q + 1'b1;
      end else if (!addr_done && bus_i.rvalid) begin
        outst_q <= outst_q - 1'b1;
      end
    end
  end

  assign flags_o = '{
    addr_ph_cont: stall_q,
    resp_ph_cont: (outst_q != '0),
    outstanding:  outst_q
  };

  // ----------------------------------------
  // grant parity
  // ----------------------------------------
  // parity is good when gntpar is the inverse of gnt
  assign gntpar_err_o = bus_i.req && ((bus_i.gnt == bus_i.gntpar) || gntpar_err_q);

  // carry an error seen during stall cycles up to the grant
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      gntpar_err_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      gntpar_err_q <= gntpar_err_o;
    end else begin
      gntpar_err_q <= 1'b0;
    end
  end

endmodule

//--- support_logic_pkg.sv
// types of the retirement-stream support monitor
// widths come from the config header
`include "support_logic_config.svh"

package support_logic_pkg;

  // one record per retired instruction
  typedef struct packed {
    logic        valid;
    logic        dbg_mode;
    logic        is_dret;
    logic        trap;
    logic        exception;
    logic [5:0]  exception_cause;
    logic        intr;
    logic [10:0] intr_cause;
    logic        is_mmode;
    logic        is_umode;
  } retire_t;

  // PC source select of the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_MRET     = 3'd2,
    PC_DRET     = 3'd3,
    PC_TRAP_DBD = 3'd4,
    PC_TRAP_IRQ = 3'd5,
    PC_TRAP_EXC = 3'd6,
    PC_TRAP_DBE = 3'd7
  } pc_mux_e;

  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } ctrl_t;

  typedef struct packed {
    logic req;
    logic gnt;
    logic gntpar;
    logic rvalid;
  } obi_bus_t;

  // trigger CSR write seen in writeback
  typedef struct packed {
    logic        valid;
    logic [2:0]  tselect;
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } trig_wr_t;

  // ----------------------------------------
  // tdata1 views
  // ----------------------------------------
  typedef struct packed {
    logic [3:0]  ttype;
    logic [27:0] data;
  } tdata1_generic_t;

  // etrigger layout, mode enables at bits 9 and 6
  typedef struct packed {
    logic [3:0]  ttype;
    logic [17:0] rsvd_27_10;
    logic        m;
    logic [1:0]  rsvd_8_7;
    logic        u;
    logic [5:0]  rsvd_5_0;
  } tdata1_etrig_t;

  typedef union packed {
    tdata1_generic_t generic;
    tdata1_etrig_t   etrig;
  } tdata1_u;

  // ----------------------------------------
  // monitor outputs
  // ----------------------------------------
  typedef struct packed {
    logic                   addr_ph_cont;
    logic                   resp_ph_cont;
    logic [`SL_OUTST_W-1:0] outstanding;
  } bus_flags_t;

  typedef struct packed {
    logic                 first_fetch;
    logic                 first_debug_ins;
    logic                 recorded_dbg_req;
    logic                 req_after_exception;
    logic                 exc_trigger_hit;
    logic [`SL_CNT_W-1:0] cnt_irq_ack;
    logic [`SL_CNT_W-1:0] cnt_rvfi_irqs;
    bus_flags_t           instr_bus;
    bus_flags_t           data_bus;
    logic                 req_was_store;
    logic                 data_req_had_integrity;
    logic                 instr_req_had_integrity;
    logic                 gntpar_err_in_resp_instr;
    logic                 gntpar_err_in_resp_data;
  } support_flags_t;

endpackage

//--- support_logic_config.svh
// sizes shared by the support monitor
// the FIFO depth must be a power of two and fit the outstanding counter
`ifndef SUPPORT_LOGIC_CONFIG_SVH
`define SUPPORT_LOGIC_CONFIG_SVH

// triggers the core implements
`define SL_NUM_TRIGGERS 4

// shadow slots, one more than the core has
`define SL_MAX_TRIGGERS 5

// event counters saturate at all ones
`define SL_CNT_W 8

// outstanding OBI transfers tracked per bus
`define SL_FIFO_DEPTH 4
`define SL_OUTST_W 3

`endif
